// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f sources.f --top-module tb_rv_id_ex_slice -o sim_tb

run: compile
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== hw/id_ex_if.sv ====
interface id_ex_if;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic     valid;
    alu_op_e  alu_op;
    sel_a_e   sel_a;
    sel_b_e   sel_b;
    logic     write_rd;
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    reg_idx_t rd_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    xlen_t    pc;
    logic     illegal;    // travels with valid high

    modport dec (output valid, alu_op, sel_a, sel_b, write_rd, rs1_addr, rs2_addr,
                 rd_addr, rs1_data, rs2_data, imm, pc, illegal);
    modport stage_in (input valid, alu_op, sel_a, sel_b, write_rd, rs1_addr, rs2_addr,
                      rd_addr, rs1_data, rs2_data, imm, pc, illegal);
    modport stage_out (output valid, alu_op, sel_a, sel_b, write_rd, rs1_addr, rs2_addr,
                       rd_addr, rs1_data, rs2_data, imm, pc, illegal);
    modport exe (input valid, alu_op, sel_a, sel_b, write_rd, rs1_addr, rs2_addr,
                 rd_addr, rs1_data, rs2_data, imm, pc, illegal);

endinterface

// ==== hw/id_ex_reg.sv ====
module id_ex_reg (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      flush_i,
    input  logic      hold_i,
    id_ex_if.stage_in  d,
    id_ex_if.stage_out q
);
    import rv_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin   // flush wins over hold
            q.valid    <= 1'b0;
            q.alu_op   <= ALU_ADD;
            q.sel_a    <= SEL_A_RS1;
            q.sel_b    <= SEL_B_RS2;
            q.write_rd <= 1'b0;
            q.rs1_addr <= '0;
            q.rs2_addr <= '0;
            q.rd_addr  <= '0;
            q.rs1_data <= '0;
            q.rs2_data <= '0;
            q.imm      <= '0;
            q.pc       <= '0;
            q.illegal  <= 1'b0;
        end else if (!hold_i) begin
            q.valid    <= d.valid;
            q.alu_op   <= d.alu_op;
            q.sel_a    <= d.sel_a;
            q.sel_b    <= d.sel_b;
            q.write_rd <= d.write_rd;
            q.rs1_addr <= d.rs1_addr;
            q.rs2_addr <= d.rs2_addr;
            q.rd_addr  <= d.rd_addr;
            q.rs1_data <= d.rs1_data;
            q.rs2_data <= d.rs2_data;
            q.imm      <= d.imm;
            q.pc       <= d.pc;
            q.illegal  <= d.illegal;
        end
    end

endmodule

// ==== hw/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10   // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_RS1  = 2'd0,
        SEL_A_PC   = 2'd1,
        SEL_A_ZERO = 2'd2
    } sel_a_e;

    typedef enum logic {
        SEL_B_RS2 = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_e;

endpackage

// ==== hw/rv_decoder.sv ====
module rv_decoder (
    input  rv_isa_pkg::inst_t    inst_i,
    input  rv_isa_pkg::xlen_t    pc_i,
    input  logic                 inst_valid_i,
    output rv_isa_pkg::reg_idx_t rs1_addr_o,
    output rv_isa_pkg::reg_idx_t rs2_addr_o,
    input  rv_isa_pkg::xlen_t    rs1_data_i,
    input  rv_isa_pkg::xlen_t    rs2_data_i,
    id_ex_if.dec                 bus
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;
    xlen_t   imm_i;
    xlen_t   imm_u;
    alu_op_e arith_op;
    logic    legal;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign alt        = inst_i[ALT_BIT];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};   // shamt sits in [25:20]
    assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
            default:    arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        legal      = 1'b1;
        bus.alu_op = ALU_ADD;
        bus.sel_a  = SEL_A_RS1;
        bus.sel_b  = SEL_B_IMM;
        bus.imm    = imm_i;
        case (opcode)
            OPC_OP: begin
                bus.sel_b  = SEL_B_RS2;
                bus.alu_op = arith_op;
            end
            OPC_OP_IMM: bus.alu_op = arith_op;
            OPC_LUI: begin
                bus.alu_op = ALU_PASS_B;
                bus.sel_a  = SEL_A_ZERO;
                bus.imm    = imm_u;
            end
            OPC_AUIPC: begin
                bus.sel_a = SEL_A_PC;
                bus.imm   = imm_u;
            end
            default: begin
                legal     = 1'b0;       // 0 + 0, result reads zero
                bus.sel_a = SEL_A_ZERO;
                bus.imm   = '0;
            end
        endcase
    end

    assign bus.valid    = inst_valid_i;
    assign bus.write_rd = inst_valid_i & legal;
    assign bus.illegal  = inst_valid_i & ~legal;
    assign bus.rs1_addr = rs1_addr_o;
    assign bus.rs2_addr = rs2_addr_o;
    assign bus.rd_addr  = inst_i[11:7];
    assign bus.rs1_data = rs1_data_i;
    assign bus.rs2_data = rs2_data_i;
    assign bus.pc       = pc_i;

endmodule

// ==== hw/rv_execute.sv ====
module rv_execute (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 hold_i,
    id_ex_if.exe                 bus,
    output logic                 wb_we_o,
    output rv_isa_pkg::reg_idx_t wb_addr_o,
    output rv_isa_pkg::xlen_t    wb_data_o,
    output logic                 result_valid_o,
    output rv_isa_pkg::reg_idx_t result_rd_o,
    output rv_isa_pkg::xlen_t    result_o,
    output logic                 illegal_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic     valid_q;
    logic     we_q;
    logic     illegal_q;
    reg_idx_t rd_q;
    xlen_t    result_q;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_out;
    shamt_t   shamt;

    // bypass from the retiring instruction
    assign rs1_val = (we_q && rd_q != '0 && rd_q == bus.rs1_addr) ? result_q : bus.rs1_data;
    assign rs2_val = (we_q && rd_q != '0 && rd_q == bus.rs2_addr) ? result_q : bus.rs2_data;

    always_comb begin
        case (bus.sel_a)
            SEL_A_RS1: op_a = rs1_val;
            SEL_A_PC:  op_a = bus.pc;
            default:   op_a = '0;
        endcase
    end

    assign op_b  = (bus.sel_b == SEL_B_IMM) ? bus.imm : rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (bus.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            default:  alu_out = op_b;   // pass b
        endcase
    end

    // write port takes the result register's next value, so rf and output update together
    assign wb_we_o   = bus.write_rd & ~hold_i;
    assign wb_addr_o = bus.rd_addr;
    assign wb_data_o = alu_out;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            we_q      <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= bus.valid & ~hold_i;   // no pulse while held
            illegal_q <= bus.illegal & ~hold_i;
            if (!hold_i) begin
                we_q <= bus.write_rd;   // bypass stays live across a hold
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            rd_q     <= bus.rd_addr;
            result_q <= alu_out;
        end
    end

    assign result_valid_o = valid_q;
    assign result_rd_o    = rd_q;
    assign result_o       = result_q;
    assign illegal_o      = illegal_q;

endmodule

// ==== hw/rv_id_ex_slice.sv ====
module rv_id_ex_slice (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 inst_valid_i,
    input  rv_isa_pkg::inst_t    inst_i,
    input  rv_isa_pkg::xlen_t    pc_i,
    input  logic                 hold_i,
    input  logic                 flush_i,
    output logic                 result_valid_o,
    output rv_isa_pkg::reg_idx_t result_rd_o,
    output rv_isa_pkg::xlen_t    result_o,
    output logic                 illegal_o
);
    import rv_isa_pkg::*;

    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    reg_idx_t wb_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    wb_data;
    logic     wb_we;

    id_ex_if dec_bus ();   // decoder -> ID/EX
    id_ex_if exe_bus ();   // ID/EX -> execute

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data)
    );

    rv_decoder u_decoder (
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_valid_i (inst_valid_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .bus          (dec_bus)
    );

    id_ex_reg u_id_ex_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .hold_i  (hold_i),
        .d       (dec_bus),
        .q       (exe_bus)
    );

    rv_execute u_execute (
        .clk            (clk),
        .rst_i          (rst_i),
        .hold_i         (hold_i),
        .bus            (exe_bus),
        .wb_we_o        (wb_we),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o),
        .illegal_o      (illegal_o)
    );

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN    = 64;
    localparam int ILEN    = 32;
    localparam int REG_NUM = 32;
    localparam int SHAMT_W = 6;     // rv64 shift amount
    localparam int ALT_BIT = 30;    // sub / sra select in funct7

    typedef logic [XLEN-1:0]            xlen_t;
    typedef logic [ILEN-1:0]            inst_t;
    typedef logic [$clog2(REG_NUM)-1:0] reg_idx_t;
    typedef logic [SHAMT_W-1:0]         shamt_t;
    typedef logic [6:0]                 opcode_t;
    typedef logic [2:0]                 funct3_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0
endpackage

// ==== hw/rv_regfile.sv ====
module rv_regfile (
    input  logic                 clk,
    input  logic                 rst_i,
    input  rv_isa_pkg::reg_idx_t raddr1_i,
    input  rv_isa_pkg::reg_idx_t raddr2_i,
    output rv_isa_pkg::xlen_t    rdata1_o,
    output rv_isa_pkg::xlen_t    rdata2_o,
    input  logic                 we_i,
    input  rv_isa_pkg::reg_idx_t waddr_i,
    input  rv_isa_pkg::xlen_t    wdata_i
);
    import rv_isa_pkg::*;

    xlen_t regs [1:REG_NUM-1];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read, no bypass of the write port
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== sources.f ====
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/id_ex_if.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/id_ex_reg.sv
hw/rv_execute.sv
hw/rv_id_ex_slice.sv
verif/tb_rv_id_ex_slice.sv

// ==== verif/slice_trace.txt ====
# valid hold flush inst(hex) pc(hex) | due rd(dec) value(hex) illegal
# the result columns give what retires two cycles after this line
1 0 0 00500093 1000 1 1 5 0
1 0 0 ffd00113 1004 1 2 fffffffffffffffd 0
1 0 0 002081b3 1008 1 3 2 0
1 0 0 40208233 100c 1 4 8 0
1 0 0 401152b3 1010 1 5 ffffffffffffffff 0
1 0 0 00115333 1014 1 6 07ffffffffffffff 0
1 0 0 001123b3 1018 1 7 1 0
1 0 0 00113433 101c 1 8 0 0
1 0 0 0020c4b3 1020 1 9 fffffffffffffff8 0
1 0 0 0020e533 1024 1 10 fffffffffffffffd 0
1 0 0 0020f5b3 1028 1 11 5 0
1 0 0 00109633 102c 1 12 a0 0
1 0 0 800006b7 1030 1 13 ffffffff80000000 0
1 0 0 00001717 1034 1 14 2034 0
1 0 0 41c6d793 1038 1 15 fffffffffffffff8 0
1 0 0 00002083 103c 1 1 0 1
1 0 0 00700013 1040 1 0 7 0
1 0 0 00100833 1044 1 16 5 0
1 0 0 12300893 1048 0 0 0 0
0 1 0 00000013 0 0 0 0 0
0 1 0 00000013 0 1 17 123 0
0 0 0 00000013 0 0 0 0 0
1 0 0 00900913 1058 0 0 0 0
0 1 0 00000013 0 0 0 0 0
0 1 1 00000013 0 0 0 0 0
1 0 1 00100993 1064 0 0 0 0
1 0 0 01390a33 1068 1 20 0 0
0 0 0 00000013 0 0 0 0 0
0 0 0 00000013 0 0 0 0 0

// ==== verif/tb_rv_id_ex_slice.sv ====
module tb_rv_id_ex_slice;
    import rv_isa_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int N_RAND    = 40;

    logic     clk = 1'b0;
    logic     rst_i;
    logic     inst_valid_i;
    logic     hold_i;
    logic     flush_i;
    inst_t    inst_i;
    xlen_t    pc_i;
    logic     result_valid_o;
    reg_idx_t result_rd_o;
    xlen_t    result_o;
    logic     illegal_o;

    xlen_t    model_regs [32];
    logic     m_valid;              // reference ID/EX slot
    inst_t    m_inst;
    xlen_t    m_pc;
    logic     p_v;                  // inputs of the running cycle
    logic     p_h;
    logic     p_f;
    inst_t    p_inst;
    xlen_t    p_pc;

    int       t_v [MAX_LINES];
    int       t_h [MAX_LINES];
    int       t_f [MAX_LINES];
    int       t_ev [MAX_LINES];
    int       t_rd [MAX_LINES];
    int       t_ill [MAX_LINES];
    inst_t    t_inst [MAX_LINES];
    xlen_t    t_pc [MAX_LINES];
    xlen_t    t_val [MAX_LINES];
    int       n_lines = 0;
    int       errors = 0;
    int       cyc = 0;
    int       seed = 29821;
    logic     loaded = 1'b0;

    always #50 clk = ~clk;

    rv_id_ex_slice u_rv_id_ex_slice (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .hold_i         (hold_i),
        .flush_i        (flush_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o),
        .illegal_o      (illegal_o)
    );

    function automatic logic legal_ref(input inst_t i);
        return i[6:0] == OPC_OP || i[6:0] == OPC_OP_IMM || i[6:0] == OPC_LUI
            || i[6:0] == OPC_AUIPC;
    endfunction

    // RV64I semantics on the architectural register state
    function automatic xlen_t alu_ref(input inst_t i, input xlen_t pc);
        xlen_t      a;
        xlen_t      b;
        xlen_t      u;
        logic [5:0] sh;
        a = model_regs[i[19:15]];
        u = {{32{i[31]}}, i[31:12], 12'b0};
        b = (i[6:0] == OPC_OP) ? model_regs[i[24:20]] : {{52{i[31]}}, i[31:20]};
        sh = b[5:0];
        if (i[6:0] == OPC_LUI) return u;
        if (i[6:0] == OPC_AUIPC) return pc + u;
        case (i[14:12])
            3'd0:    return (i[6:0] == OPC_OP && i[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return i[30] ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(output logic ev, output reg_idx_t erd, output xlen_t eval,
                              output logic eill);
        ev = 1'b0;
        erd = '0;
        eval = '0;
        eill = 1'b0;
        if (!p_h && m_valid) begin
            ev = 1'b1;
            erd = m_inst[11:7];
            eill = !legal_ref(m_inst);
            if (!eill) begin
                eval = alu_ref(m_inst, m_pc);
                if (erd != 0) model_regs[erd] = eval;   // x0 stays zero
            end
        end
        if (p_f) begin
            m_valid = 1'b0;
        end else if (!p_h) begin
            m_valid = p_v;
            m_inst = p_inst;
            m_pc = p_pc;
        end
    endtask

    function automatic inst_t rand_inst();
        int         kind;
        int         f3;
        int         rd;
        int         r1;
        int         r2;
        int         r;
        logic       alt;
        logic [11:0] imm12;
        kind = {$random(seed)} % 4;
        f3 = {$random(seed)} % 8;
        rd = 1 + {$random(seed)} % 7;
        r1 = 1 + {$random(seed)} % 7;
        r2 = 1 + {$random(seed)} % 7;
        r = $random(seed);
        alt = ($random(seed) % 2) != 0;
        if (kind == 1) begin
            imm12 = r[11:0];
            if (f3 == 1) imm12 = {6'b0, r[5:0]};
            if (f3 == 5) imm12 = {1'b0, alt, 4'b0, r[5:0]};
            return {imm12, r1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
        end
        if (kind == 2) return {r[19:0], rd[4:0], OPC_LUI};
        alt = alt && (f3 == 0 || f3 == 5);
        return {1'b0, alt, 5'b0, r2[4:0], r1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    task automatic run_cycle(input logic v, input logic h, input logic f, input inst_t inst,
                             input xlen_t pc);
        logic     ev;
        logic     eill;
        reg_idx_t erd;
        xlen_t    eval;
        int       j;
        @(posedge clk);
        model_step(ev, erd, eval, eill);
        #5;
        assert (result_valid_o === ev) else begin
            errors++;
            if (ev) $display("%0t: expected result for x%0d did not appear", $time, erd);
            else $display("%0t: unexpected result pulse on result_valid_o", $time);
        end
        if (ev && result_valid_o) begin
            assert (result_rd_o === erd) else begin
                errors++;
                $display("CHECK FAILED %0t: rd %0d, expected %0d", $time, result_rd_o, erd);
            end
            assert (illegal_o === eill) else begin
                errors++;
                $display("CHECK FAILED %0t: illegal %b, expected %b", $time, illegal_o, eill);
            end
            if (!eill) begin
                assert (result_o === eval) else begin
                    errors++;
                    $display("CHECK FAILED %0t: x%0d = %h, expected %h", $time, erd,
                             result_o, eval);
                end
            end
        end else if (!ev) begin
            assert (illegal_o === 1'b0) else begin
                errors++;
                $display("CHECK FAILED %0t: illegal_o high with no result", $time);
            end
        end
        j = cyc - 2;   // trace record of the line two cycles back
        if (j >= 0 && j < n_lines) begin
            assert (t_ev[j] == int'(ev) && (!ev || (t_rd[j] == int'(erd)
                    && t_val[j] == eval && t_ill[j] == int'(eill)))) else begin
                errors++;
                $display("CHECK FAILED %0t: trace line %0d disagrees with model", $time, j);
            end
        end
        inst_valid_i = v;
        hold_i = h;
        flush_i = f;
        inst_i = inst;
        pc_i = pc;
        p_v = v;
        p_h = h;
        p_f = f;
        p_inst = inst;
        p_pc = pc;
        cyc++;
    endtask

    initial begin
        wait (loaded);
        #((n_lines + N_RAND + 20) * 100);
        $display("timeout: DUT did not finish the test sequence in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int    fd;
        int    code;
        string line;
        rst_i = 1'b1;
        inst_valid_i = 1'b0;
        hold_i = 1'b0;
        flush_i = 1'b0;
        inst_i = NOP_INST;
        pc_i = '0;
        p_v = 1'b0;
        p_h = 1'b0;
        p_f = 1'b0;
        p_inst = NOP_INST;
        p_pc = '0;
        m_valid = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        fd = $fopen("verif/slice_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/slice_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %d %d %h %h %d %d %h %d", t_v[n_lines],
                                t_h[n_lines], t_f[n_lines], t_inst[n_lines], t_pc[n_lines],
                                t_ev[n_lines], t_rd[n_lines], t_val[n_lines],
                                t_ill[n_lines]) == 9) begin
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #5 rst_i = 1'b0;
        for (int k = 0; k < n_lines; k++) begin
            run_cycle(t_v[k] != 0, t_h[k] != 0, t_f[k] != 0, t_inst[k], t_pc[k]);
        end
        for (int k = 0; k < N_RAND; k++) begin
            run_cycle(1'b1, 1'b0, 1'b0, rand_inst(), xlen_t'(64'h2000 + 4 * k));
        end
        // dependent add held in ID/EX right behind its producer
        run_cycle(1'b1, 1'b0, 1'b0, 32'h00b00093, 64'h3000);   // addi x1, x0, 11
        run_cycle(1'b1, 1'b0, 1'b0, 32'h00108133, 64'h3004);   // add x2, x1, x1
        run_cycle(1'b0, 1'b1, 1'b0, NOP_INST, '0);
        repeat (3) run_cycle(1'b0, 1'b0, 1'b0, NOP_INST, '0);   // drain
        $display("checks done over %0d cycles, errors: %0d", cyc, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
